/* design/m92_bus_pkg.sv */
//==========================================================
// Shared definitions for the CPU-side bus controller
// Memory map bounds, SDRAM bases, I/O port numbers,
// region enumeration and the I/O read word union
//==========================================================
`default_nettype none

package m92_bus_pkg;

    // Bus widths
    localparam int cpu_addr_w = 20;
    localparam int sdr_addr_w = 25;
    localparam int bank_w     = 4;

    // Window sizes as address bits
    localparam int bank_win_w = 17;                         // 128K per bank
    localparam int ram_win_w  = 16;                         // 64K work RAM

    //==========================================================
    // Memory map
    //==========================================================
    localparam logic [cpu_addr_w-1:0] rom_end    = 20'hA0000;
    localparam logic [cpu_addr_w-1:0] bank_start = 20'hA0000;
    localparam logic [cpu_addr_w-1:0] bank_end   = 20'hC0000;
    localparam logic [cpu_addr_w-1:0] ram_start  = 20'hE0000;
    localparam logic [cpu_addr_w-1:0] ram_end    = 20'hF0000;

    localparam logic [sdr_addr_w-1:0] bank_rom_base = 25'h100000;
    localparam logic [sdr_addr_w-1:0] ram_base      = 25'h400000;

    // I/O ports, even byte address of each word
    localparam logic [7:0] io_port_p1_p2 = 8'h00;
    localparam logic [7:0] io_port_flags = 8'h02;
    localparam logic [7:0] io_port_dip   = 8'h04;
    localparam logic [7:0] io_port_p3_p4 = 8'h06;
    localparam logic [7:0] io_port_bank  = 8'h20;           // Write only

    typedef enum logic [1:0] {none, rom, bank_rom, ram} region_e;

    // I/O read word, odd port takes the high byte
    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [7:0] hi;
            logic [7:0] lo;
        } bytes;
    } io_word_u;

endpackage

`default_nettype wire

/* design/bus_address_map.sv */
//==========================================================
// Memory map decoder
// Region select, SDRAM word address and write permission
//==========================================================
`default_nettype none

module bus_address_map import m92_bus_pkg::*; (
    input  wire logic [cpu_addr_w-1:0] cpu_mem_addr,
    input  wire logic [bank_w-1:0]     bank_select,
    output region_e                    region,
    output logic [sdr_addr_w-1:0]      sdr_word_addr,
    output logic                       writable
);

    logic [cpu_addr_w-1:0] word_addr;
    logic [cpu_addr_w-1:0] bank_off;
    logic [cpu_addr_w-1:0] ram_off;

    assign word_addr = {cpu_mem_addr[cpu_addr_w-1:1], 1'b0};   // Word aligned
    assign bank_off  = word_addr - bank_start;
    assign ram_off   = word_addr - ram_start;

    always_comb begin
        if (cpu_mem_addr < rom_end) begin
            region = rom;
        end else if (cpu_mem_addr >= bank_start && cpu_mem_addr < bank_end) begin
            region = bank_rom;
        end else if (cpu_mem_addr >= ram_start && cpu_mem_addr < ram_end) begin
            region = ram;
        end else begin
            region = none;
        end
    end

    always_comb begin
        case (region)
            rom:      sdr_word_addr = sdr_addr_w'(word_addr);
            bank_rom: sdr_word_addr = bank_rom_base
                                    + sdr_addr_w'({bank_select, {bank_win_w{1'b0}}})
                                    + sdr_addr_w'(bank_off[bank_win_w-1:0]);
            ram:      sdr_word_addr = ram_base + sdr_addr_w'(ram_off[ram_win_w-1:0]);
            default:  sdr_word_addr = '0;
        endcase
    end

    // Only work RAM accepts writes
    assign writable = (region == ram);

endmodule

`default_nettype wire

/* design/sdram_request_fsm.sv */
//==========================================================
// CPU SDRAM request state machine
// Single request per access, byte lane steering,
// read capture and odd byte shuffle onto the CPU bus
//==========================================================
`default_nettype none

module sdram_request_fsm import m92_bus_pkg::*; #(
    parameter int sdr_addr_w = m92_bus_pkg::sdr_addr_w
) (
    input  wire logic                  clk_sys,
    input  wire logic                  reset_n,
    input  wire logic                  cpu_mem_read,
    input  wire logic                  cpu_mem_write,
    input  wire logic [cpu_addr_w-1:0] cpu_mem_addr,
    input  wire logic [1:0]            cpu_mem_sel,
    input  wire logic [15:0]           cpu_mem_dout,
    input  wire region_e               region,
    input  wire logic [sdr_addr_w-1:0] sdr_word_addr,
    input  wire logic                  writable,
    output logic [15:0]                cpu_mem_din,
    output logic                       mem_busy,
    output logic                       sdr_req,
    output logic [sdr_addr_w-1:0]      sdr_addr,
    output logic [15:0]                sdr_din,
    output logic [1:0]                 sdr_wr_sel,
    input  wire logic [15:0]           sdr_dout,
    input  wire logic                  sdr_rdy
);

    typedef enum logic {idle, wait_rdy} state_e;

    state_e      state;
    logic [15:0] rd_data;
    logic        mem_strobe;
    logic        wr_access;
    logic [1:0]  lane_sel;
    logic [15:0] lane_data;

    assign mem_strobe = (cpu_mem_read | cpu_mem_write) & (region != none);
    assign wr_access  = cpu_mem_write & writable;      // ROM writes go out as reads
    assign mem_busy   = (state == wait_rdy);

    // Odd address moves the low byte and its lane up
    assign lane_sel  = cpu_mem_addr[0] ? {cpu_mem_sel[0], 1'b0} : cpu_mem_sel;
    assign lane_data = cpu_mem_addr[0] ? {cpu_mem_dout[7:0], 8'h00} : cpu_mem_dout;

    //==========================================================
    // Control
    //==========================================================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            state      <= idle;
            sdr_req    <= 1'b0;
            sdr_wr_sel <= 2'b00;
        end else begin
            sdr_req <= 1'b0;                            // One cycle strobe
            case (state)
                idle: begin
                    if (mem_strobe) begin
                        sdr_req    <= 1'b1;
                        sdr_wr_sel <= wr_access ? lane_sel : 2'b00;
                        state      <= wait_rdy;
                    end
                end
                wait_rdy: begin
                    if (sdr_rdy) begin
                        sdr_wr_sel <= 2'b00;
                        state      <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request payload and returned data
    always_ff @(posedge clk_sys) begin
        if (state == idle && mem_strobe) begin
            sdr_addr <= sdr_word_addr;
            if (wr_access) sdr_din <= lane_data;
        end
        if (state == wait_rdy && sdr_rdy) rd_data <= sdr_dout;
    end

    // Unmapped reads float high
    assign cpu_mem_din = (region == none) ? 16'hFFFF :
                         cpu_mem_addr[0]  ? {8'h00, rd_data[15:8]} : rd_data;

    // Only the first cycle of a wait may carry the request
    a_req_once: assert property (@(posedge clk_sys) disable iff (!reset_n)
        (state == wait_rdy) && $past(state == wait_rdy) |-> !sdr_req);

endmodule

`default_nettype wire

/* design/cpu_clock_enable.sv */
//==========================================================
// CPU clock enables
// Divide counter, SDRAM stall gating and vblank pause latch
//==========================================================
`default_nettype none

module cpu_clock_enable import m92_bus_pkg::*; #(
    parameter int ce_div_bits = 2
) (
    input  wire logic     clk_sys,
    input  wire logic     reset_n,
    input  wire logic     cpu_mem_read,
    input  wire logic     cpu_mem_write,
    input  wire region_e  region,
    input  wire logic     mem_busy,
    input  wire logic     pause_rq,
    input  wire logic     vpulse,
    output logic          ce_4x_cpu,
    output logic          ce_cpu,
    output logic          paused
);

    logic [ce_div_bits-1:0] ce_count;
    logic                   ce_run;                     // Set once out of reset
    logic                   mem_strobe;
    logic                   stall;

    assign mem_strobe = (cpu_mem_read | cpu_mem_write) & (region != none);
    assign stall      = mem_strobe | mem_busy | paused | ~ce_run;

    assign ce_4x_cpu = ~stall;
    assign ce_cpu    = ce_4x_cpu & (&ce_count);         // Every fourth pulse

    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            ce_run   <= 1'b0;
            ce_count <= '0;
            paused   <= 1'b0;
        end else begin
            ce_run <= 1'b1;
            if (ce_4x_cpu) ce_count <= ce_count + ce_div_bits'(1);

            // Pause only takes effect at vertical pulse
            if (pause_rq && !paused) begin
                if (vpulse && !cpu_mem_read && !cpu_mem_write && !mem_busy) paused <= 1'b1;
            end else if (!pause_rq && paused && vpulse) begin
                paused <= 1'b0;
            end
        end
    end

    a_ce_cpu: assert property (@(posedge clk_sys) disable iff (!reset_n)
        ce_cpu |-> ce_4x_cpu ##1 !ce_cpu);

endmodule

`default_nettype wire

/* design/io_port_block.sv */
//==========================================================
// CPU I/O ports
// Bank select register and read mux for switches,
// coin and start flags and DIP switches
//==========================================================
`default_nettype none

module io_port_block import m92_bus_pkg::*; (
    input  wire logic        clk_sys,
    input  wire logic        reset_n,
    input  wire logic        cpu_io_read,
    input  wire logic        cpu_io_write,
    input  wire logic [7:0]  cpu_io_addr,
    input  wire logic [7:0]  cpu_io_dout,

    // Buttons then directions, active high
    input  wire logic [7:0]  p1_input,
    input  wire logic [7:0]  p2_input,
    input  wire logic [7:0]  p3_input,
    input  wire logic [7:0]  p4_input,
    input  wire logic [1:0]  coin,
    input  wire logic [1:0]  start_buttons,
    input  wire logic [23:0] dip_sw,

    output logic [7:0]       cpu_io_din,
    output logic [bank_w-1:0] bank_select
);

    io_word_u   io_word;
    logic [7:0] word_port;

    //==========================================================
    // Bank select
    //==========================================================
    always_ff @(posedge clk_sys or negedge reset_n) begin
        if (!reset_n) begin
            bank_select <= '0;
        end else if (cpu_io_write && cpu_io_addr == io_port_bank) begin
            bank_select <= cpu_io_dout[bank_w-1:0];
        end
    end

    //==========================================================
    // Read mux
    //==========================================================
    assign word_port = {cpu_io_addr[7:1], 1'b0};

    // Inputs read back active low
    always_comb begin
        case (word_port)
            io_port_p1_p2: io_word.word = {~p2_input, ~p1_input};
            io_port_flags: io_word.word = {~dip_sw[23:16], 4'b1111, ~coin, ~start_buttons};
            io_port_dip:   io_word.word = ~dip_sw[15:0];
            io_port_p3_p4: io_word.word = {~p4_input, ~p3_input};
            default:       io_word.word = 16'hFFFF;
        endcase
    end

    assign cpu_io_din = cpu_io_addr[0] ? io_word.bytes.hi : io_word.bytes.lo;

    // The CPU never strobes both directions at once
    a_io_excl: assert property (@(posedge clk_sys) disable iff (!reset_n)
        cpu_io_write |-> !cpu_io_read);

endmodule

`default_nettype wire

/* design/m92_bus_top.sv */
//==========================================================
// CPU-side bus controller top level
// Address map, SDRAM requests, clock enables and I/O ports
//==========================================================
`default_nettype none

module m92_bus_top import m92_bus_pkg::*; #(
    parameter int ce_div_bits = 2,
    parameter int sdr_addr_w  = m92_bus_pkg::sdr_addr_w
) (
    input  wire logic                  clk_sys,
    input  wire logic                  reset_n,

    // CPU memory bus
    input  wire logic                  cpu_mem_read,
    input  wire logic                  cpu_mem_write,
    input  wire logic [cpu_addr_w-1:0] cpu_mem_addr,
    input  wire logic [1:0]            cpu_mem_sel,
    input  wire logic [15:0]           cpu_mem_dout,
    output logic [15:0]                cpu_mem_din,

    // CPU I/O bus
    input  wire logic                  cpu_io_read,
    input  wire logic                  cpu_io_write,
    input  wire logic [7:0]            cpu_io_addr,
    input  wire logic [7:0]            cpu_io_dout,
    output logic [7:0]                 cpu_io_din,

    input  wire logic [7:0]            p1_input,
    input  wire logic [7:0]            p2_input,
    input  wire logic [7:0]            p3_input,
    input  wire logic [7:0]            p4_input,
    input  wire logic [1:0]            coin,
    input  wire logic [1:0]            start_buttons,
    input  wire logic [23:0]           dip_sw,

    input  wire logic                  pause_rq,
    input  wire logic                  vpulse,
    output logic                       ce_4x_cpu,
    output logic                       ce_cpu,
    output logic                       paused,

    // SDRAM port
    output logic [sdr_addr_w-1:0]      sdr_addr,
    output logic [15:0]                sdr_din,
    output logic [1:0]                 sdr_wr_sel,
    output logic                       sdr_req,
    input  wire logic [15:0]           sdr_dout,
    input  wire logic                  sdr_rdy
);

    region_e               region;
    logic [sdr_addr_w-1:0] sdr_word_addr;
    logic                  writable;
    logic                  mem_busy;
    logic [bank_w-1:0]     bank_select;

    bus_address_map u_map (
        .cpu_mem_addr, .bank_select, .region, .sdr_word_addr, .writable
    );

    sdram_request_fsm #(.sdr_addr_w(sdr_addr_w)) u_sdram (
        .clk_sys, .reset_n,
        .cpu_mem_read, .cpu_mem_write, .cpu_mem_addr, .cpu_mem_sel, .cpu_mem_dout,
        .region, .sdr_word_addr, .writable,
        .cpu_mem_din, .mem_busy,
        .sdr_req, .sdr_addr, .sdr_din, .sdr_wr_sel, .sdr_dout, .sdr_rdy
    );

    // Sees the raw strobes so the strobe cycle itself stalls
    cpu_clock_enable #(.ce_div_bits(ce_div_bits)) u_ce (
        .clk_sys, .reset_n, .cpu_mem_read, .cpu_mem_write, .region, .mem_busy,
        .pause_rq, .vpulse, .ce_4x_cpu, .ce_cpu, .paused
    );

    io_port_block u_io (
        .clk_sys, .reset_n, .cpu_io_read, .cpu_io_write, .cpu_io_addr, .cpu_io_dout,
        .p1_input, .p2_input, .p3_input, .p4_input, .coin, .start_buttons, .dip_sw,
        .cpu_io_din, .bank_select
    );

endmodule

`default_nettype wire

/* test/bus_model.svh */
//==========================================================
// Reference model for the bus controller testbench
// Address map, byte lane steering, read shuffle, I/O reads
//==========================================================
`ifndef BUS_MODEL_SVH
`define BUS_MODEL_SVH

function automatic region_e region_of(input logic [cpu_addr_w-1:0] a);
    if (a < rom_end) return rom;
    if (a >= bank_start && a < bank_end) return bank_rom;
    if (a >= ram_start && a < ram_end) return ram;
    return none;
endfunction

function automatic logic [sdr_addr_w-1:0] sdram_addr_of(input logic [cpu_addr_w-1:0] a,
                                                        input logic [bank_w-1:0] bank);
    logic [cpu_addr_w-1:0] w;
    w = {a[cpu_addr_w-1:1], 1'b0};                  // Word aligned
    case (region_of(a))
        rom:      return 25'(w);
        bank_rom: return bank_rom_base + 25'(bank) * 25'h20000 + 25'(w - bank_start);
        ram:      return ram_base + 25'(w - ram_start);
        default:  return '0;
    endcase
endfunction

// Odd address moves the low byte and its lane up
function automatic logic [1:0] lanes_for(input logic odd, input logic [1:0] sel);
    return odd ? {sel[0], 1'b0} : sel;
endfunction

function automatic logic [15:0] lane_data_for(input logic odd, input logic [15:0] d);
    return odd ? {d[7:0], 8'h00} : d;
endfunction

function automatic logic [15:0] merge_word(input logic [15:0] old, input logic [15:0] d,
                                           input logic [1:0] lanes);
    return {lanes[1] ? d[15:8] : old[15:8], lanes[0] ? d[7:0] : old[7:0]};
endfunction

function automatic logic [15:0] shuffle_read(input logic [15:0] w, input logic odd);
    return odd ? {8'h00, w[15:8]} : w;
endfunction

function automatic logic [7:0] io_byte_for(input logic [7:0] port,
                                           input logic [7:0] p1, input logic [7:0] p2,
                                           input logic [7:0] p3, input logic [7:0] p4,
                                           input logic [1:0] cn, input logic [1:0] st,
                                           input logic [23:0] dip);
    io_word_u w;
    case (port & 8'hFE)
        io_port_p1_p2: w.word = {~p2, ~p1};
        io_port_flags: w.word = {~dip[23:16], 4'b1111, ~cn, ~st};
        io_port_dip:   w.word = ~dip[15:0];
        io_port_p3_p4: w.word = {~p4, ~p3};
        default:       w.word = 16'hFFFF;
    endcase
    return port[0] ? w.bytes.hi : w.bytes.lo;       // Odd port reads the high byte
endfunction

`endif

/* test/tb_m92_bus.sv */
//==========================================================
// Testbench for the CPU-side bus controller
// Clock and reset, SDRAM responder, LCG stimulus,
// six tests checked against the reference model
//==========================================================
`default_nettype none

module tb_m92_bus import m92_bus_pkg::*; ;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk_sys = 1'b0;
    logic reset_n;
    logic cpu_mem_read, cpu_mem_write, cpu_io_read, cpu_io_write;
    logic [cpu_addr_w-1:0] cpu_mem_addr;
    logic [1:0]  cpu_mem_sel, coin, start_buttons, sdr_wr_sel;
    logic [15:0] cpu_mem_dout, cpu_mem_din, sdr_din, sdr_dout;
    logic [7:0]  cpu_io_addr, cpu_io_dout, cpu_io_din;
    logic [7:0]  p1_input, p2_input, p3_input, p4_input;
    logic [23:0] dip_sw;
    logic pause_rq, vpulse, ce_4x_cpu, ce_cpu, paused, sdr_req, sdr_rdy;
    logic [sdr_addr_w-1:0] sdr_addr;

    logic [31:0] rnd_state  = 32'he514;
    logic [31:0] resp_state = 32'he514;             // Responder has its own stream
    logic [15:0] sdram_mem [logic [sdr_addr_w-1:0]];
    int err_count = 0;
    int n_checks  = 0;
    int test_base = 0;

    `include "bus_model.svh"

    m92_bus_top #(.ce_div_bits(2), .sdr_addr_w(sdr_addr_w)) i_dut (
        .clk_sys, .reset_n, .cpu_mem_read, .cpu_mem_write, .cpu_mem_addr, .cpu_mem_sel,
        .cpu_mem_dout, .cpu_mem_din, .cpu_io_read, .cpu_io_write, .cpu_io_addr,
        .cpu_io_dout, .cpu_io_din, .p1_input, .p2_input, .p3_input, .p4_input, .coin,
        .start_buttons, .dip_sw, .pause_rq, .vpulse, .ce_4x_cpu, .ce_cpu, .paused,
        .sdr_addr, .sdr_din, .sdr_wr_sel, .sdr_req, .sdr_dout, .sdr_rdy
    );

    always #2 clk_sys = ~clk_sys;                   // 4 ns period

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic get_rand(output logic [31:0] r);
        rnd_state = lcg_next(rnd_state);
        r = {rnd_state[15:0], rnd_state[31:16]};    // High bits are the better ones
    endtask

    // Unwritten SDRAM words hold a pattern of the whole address
    function automatic logic [15:0] sdram_word(input logic [sdr_addr_w-1:0] a);
        if (sdram_mem.exists(a)) return sdram_mem[a];
        return a[15:0] ^ {7'b0, a[24:16]} ^ 16'hA5C3;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d errors", name, err_count - test_base);
        test_base = err_count;
    endtask

    task automatic wait_for_ce(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (ce_4x_cpu !== level && n < limit) begin
            @(negedge clk_sys);
            n++;
        end
        if (ce_4x_cpu !== level) begin
            $display("timeout while waiting for %s", what);
            err_count++;
        end
    endtask

    task automatic io_write(input logic [7:0] port, input logic [7:0] data);
        @(negedge clk_sys);
        cpu_io_write = 1'b1;
        cpu_io_addr  = port;
        cpu_io_dout  = data;
        @(negedge clk_sys);
        cpu_io_write = 1'b0;
    endtask

    // One CPU access to a mapped region, returns the request and the read data
    task automatic mem_access(input logic wr, input logic [cpu_addr_w-1:0] addr,
                              input logic [1:0] sel, input logic [15:0] dout,
                              output logic [sdr_addr_w-1:0] req_addr,
                              output logic [15:0] req_din, output logic [1:0] req_sel,
                              output logic [15:0] din);
        @(negedge clk_sys);
        cpu_mem_read  = !wr;
        cpu_mem_write = wr;
        cpu_mem_addr  = addr;
        cpu_mem_sel   = sel;
        cpu_mem_dout  = dout;
        @(negedge clk_sys);
        check_value("sdr_req", 32'(sdr_req), 32'h1);     // Request one cycle after strobe
        req_addr = sdr_addr;
        req_din  = sdr_din;
        req_sel  = sdr_wr_sel;
        cpu_mem_read  = 1'b0;
        cpu_mem_write = 1'b0;
        wait_for_ce(1'b1, 40, "the end of a memory access");
        din = cpu_mem_din;
    endtask

    //==========================================================
    // SDRAM responder
    //==========================================================
    initial begin : responder
        logic [31:0] delay;
        forever begin
            @(negedge clk_sys);
            if (reset_n && sdr_req) begin
                resp_state = lcg_next(resp_state);
                delay = 32'd1 + (resp_state[31:16] % 32'd8);
                if (sdr_wr_sel != 2'b00)
                    sdram_mem[sdr_addr] = merge_word(sdram_word(sdr_addr), sdr_din, sdr_wr_sel);
                repeat (delay) @(negedge clk_sys);
                sdr_dout = sdram_word(sdr_addr);
                sdr_rdy  = 1'b1;
                @(negedge clk_sys);
                sdr_rdy  = 1'b0;
            end
        end
    end

    //==========================================================
    // Tests
    //==========================================================
    initial begin : tests
        logic [31:0] r;
        logic [cpu_addr_w-1:0] addr;
        logic [sdr_addr_w-1:0] ra, saddr;
        logic [15:0] rd, din, data, exp_word;
        logic [1:0]  rs, sel, lanes;
        logic [3:0]  bank;
        logic [7:0]  port;
        int n4, n1;
        reset_n = 1'b0;
        cpu_mem_read = 1'b0;
        cpu_mem_write = 1'b0;
        cpu_mem_addr = '0;
        cpu_mem_sel = 2'b00;
        cpu_mem_dout = '0;
        cpu_io_read = 1'b0;
        cpu_io_write = 1'b0;
        cpu_io_addr = '0;
        cpu_io_dout = '0;
        p1_input = '0;
        p2_input = '0;
        p3_input = '0;
        p4_input = '0;
        coin = '0;
        start_buttons = '0;
        dip_sw = '0;
        pause_rq = 1'b0;
        vpulse = 1'b0;
        sdr_dout = '0;
        sdr_rdy = 1'b0;
        bank = 4'h0;

        for (int i = 0; i < 4; i++) begin
            @(negedge clk_sys);
            check_value("ce_cpu", 32'(ce_cpu), 32'h0);
            check_value("ce_4x_cpu", 32'(ce_4x_cpu), 32'h0);
            check_value("sdr_req", 32'(sdr_req), 32'h0);
            check_value("sdr_wr_sel", 32'(sdr_wr_sel), 32'h0);
            check_value("paused", 32'(paused), 32'h0);
        end
        reset_n = 1'b1;
        end_test("test 1 reset state");

        n4 = 0;
        n1 = 0;
        for (int i = 0; i < 64; i++) begin
            @(negedge clk_sys);
            if (ce_4x_cpu) n4++;
            if (ce_cpu) n1++;
        end
        check_value("ce_4x_cpu pulses", 32'(n4), 32'd64);
        check_value("ce_cpu pulses", 32'(n1), 32'd16);
        end_test("test 2 clock enables");

        for (int i = 0; i < 20; i++) begin
            get_rand(r);
            bank = r[3:0];
            io_write(io_port_bank, {4'h0, bank});
            get_rand(r);
            if (r[31]) addr = 20'(r % 32'hA0000);
            else addr = bank_start + {3'b000, r[16:0]};
            saddr = sdram_addr_of(addr, bank);
            exp_word = shuffle_read(sdram_word(saddr), addr[0]);
            mem_access(1'b0, addr, 2'b11, 16'h0000, ra, rd, rs, din);
            check_value("sdr_addr", 32'(ra), 32'(saddr));
            check_value("sdr_wr_sel", 32'(rs), 32'h0);
            check_value("cpu_mem_din", 32'(din), 32'(exp_word));
        end
        get_rand(r);
        mem_access(1'b1, 20'(r % 32'hA0000), 2'b11, r[15:0], ra, rd, rs, din);
        check_value("sdr_wr_sel", 32'(rs), 32'h0);           // ROM write goes out as a read
        end_test("test 3 rom and banked reads");

        for (int i = 0; i < 16; i++) begin
            get_rand(r);
            addr = ram_start + {4'h0, r[15:0]};
            sel = (r[17:16] == 2'b00) ? 2'b11 : r[17:16];
            get_rand(r);
            data = r[15:0];
            lanes = lanes_for(addr[0], sel);
            saddr = sdram_addr_of(addr, bank);
            exp_word = merge_word(sdram_word(saddr), lane_data_for(addr[0], data), lanes);
            mem_access(1'b1, addr, sel, data, ra, rd, rs, din);
            check_value("sdr_addr", 32'(ra), 32'(saddr));
            check_value("sdr_wr_sel", 32'(rs), 32'(lanes));
            if (lanes != 2'b00) check_value("sdr_din", 32'(rd), 32'(lane_data_for(addr[0], data)));
            mem_access(1'b0, addr, 2'b11, 16'h0000, ra, rd, rs, din);
            check_value("cpu_mem_din", 32'(din), 32'(shuffle_read(exp_word, addr[0])));
        end
        end_test("test 4 ram writes and reads");

        get_rand(r);
        @(negedge clk_sys);
        {p4_input, p3_input, p2_input, p1_input} = r;
        get_rand(r);
        dip_sw = r[23:0];
        coin = r[25:24];
        start_buttons = r[27:26];
        for (int i = 0; i < 12; i++) begin
            get_rand(r);
            if (i < 8) port = 8'(i);
            else if (i < 10) port = io_port_bank | 8'(i - 8);
            else port = {2'b01, r[5:0]};
            @(negedge clk_sys);
            cpu_io_read = 1'b1;
            cpu_io_addr = port;
            #1;
            check_value("cpu_io_din", 32'(cpu_io_din), 32'(io_byte_for(port, p1_input,
                        p2_input, p3_input, p4_input, coin, start_buttons, dip_sw)));
        end
        @(negedge clk_sys);
        cpu_io_read = 1'b0;
        get_rand(r);
        cpu_mem_read = 1'b1;
        cpu_mem_addr = r[31] ? {3'b110, r[16:0]} : {4'hF, r[15:0]};
        #1;
        check_value("cpu_mem_din", 32'(cpu_mem_din), 32'h0000FFFF);
        @(negedge clk_sys);
        check_value("sdr_req", 32'(sdr_req), 32'h0);        // Unmapped, no request
        cpu_mem_read = 1'b0;
        @(negedge clk_sys);
        check_value("sdr_req", 32'(sdr_req), 32'h0);
        end_test("test 5 io reads and unmapped memory");

        @(negedge clk_sys);
        pause_rq = 1'b1;
        repeat (3) begin
            @(negedge clk_sys);
            check_value("ce_4x_cpu", 32'(ce_4x_cpu), 32'h1);  // Runs until vpulse
        end
        vpulse = 1'b1;
        @(negedge clk_sys);
        vpulse = 1'b0;
        wait_for_ce(1'b0, 4, "pause to take effect");
        for (int i = 0; i < 50; i++) begin
            @(negedge clk_sys);
            check_value("ce_4x_cpu", 32'(ce_4x_cpu), 32'h0);
            check_value("ce_cpu", 32'(ce_cpu), 32'h0);
            check_value("paused", 32'(paused), 32'h1);
            vpulse = (i == 20);
        end
        pause_rq = 1'b0;
        repeat (5) begin
            @(negedge clk_sys);
            check_value("ce_4x_cpu", 32'(ce_4x_cpu), 32'h0);  // Still paused until vpulse
        end
        vpulse = 1'b1;
        @(negedge clk_sys);
        vpulse = 1'b0;
        wait_for_ce(1'b1, 4, "resume after pause");
        check_value("paused", 32'(paused), 32'h0);
        end_test("test 6 pause");

        $display("tests 6, checks %0d, errors %0d", n_checks, err_count);
        if (err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+test
design/m92_bus_pkg.sv
design/bus_address_map.sv
design/sdram_request_fsm.sv
design/cpu_clock_enable.sv
design/io_port_block.sv
design/m92_bus_top.sv
test/tb_m92_bus.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bus controller testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sim.f --top-module tb_m92_bus &&
sim_out="$(./obj_dir/Vtb_m92_bus)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "Finished with no errors" && exit 0 || exit 1
